/* project.f */
rtl/video_pkg.sv
rtl/obj_pkg.sv
rtl/video_timing.sv
rtl/obj_scan_ctrl.sv
rtl/obj_attr_ram.sv
rtl/obj_draw.sv
rtl/obj_linebuf.sv
rtl/obj_engine_top.sv
sim/tb_clock_gen.sv
sim/obj_engine_checker.sv
sim/obj_engine_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the object engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module obj_engine_tb \
    -f project.f \
    --Mdir obj_dir \
    -o obj_engine_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/obj_engine_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit 1
fi

exit 0

/* sim/obj_engine_tb.sv */
`timescale 1ns/10ps

// testbench for the scanline object engine
module obj_engine_tb;

    localparam int FRAME_CYCLES    = video_pkg::H_TOTAL * video_pkg::V_TOTAL;
    localparam int FRAME_PIXELS    = video_pkg::H_ACTIVE * video_pkg::V_ACTIVE;
    localparam int WB_TIMEOUT      = 20;
    localparam int ROM_MAX_WAIT    = 3;
    // keeps the per line scan inside one line at the worst rom delay
    localparam int MAX_RANDOM_OBJS = 5;

    logic               clk;
    logic               rst;
    obj_pkg::wb_req_t   wb_req   = '0;
    obj_pkg::wb_rsp_t   wb_rsp;
    obj_pkg::rom_req_t  rom_req;
    logic               rom_ok   = 1'b0;
    obj_pkg::rom_word_t rom_data = '0;
    obj_pkg::pix_out_t  pix_out;

    int                 seed = 48;
    string              test_name = "reset";
    int                 error_count = 0;
    int                 pix_seen = 0;
    int                 opaque_seen = 0;
    logic               check_en = 1'b0;
    logic               rom_busy = 1'b0;
    int                 rom_wait = 0;
    obj_pkg::pix_out_t  exp_place;
    // copy of what the cpu wrote, used by the reference
    obj_pkg::obj_attr_t attr_tab [obj_pkg::OBJ_SLOTS];

    tb_clock_gen u_clk (
        .clk (clk),
        .rst (rst)
    );

    obj_engine_top uut (
        .clk      (clk),
        .rst      (rst),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp),
        .rom_req  (rom_req),
        .rom_ok   (rom_ok),
        .rom_data (rom_data),
        .pix_out  (pix_out)
    );

    task automatic fail_with(input string msg);
        $display("%s", msg);
        error_count++;
        $display("Testbench failed");
        $fatal(1, "run stopped at first error");
    endtask

    // graphics rom contents, hash of the whole address
    function automatic obj_pkg::rom_word_t rom_word_at(input int addr);
        logic [15:0]        h;
        logic [3:0]         n;
        obj_pkg::rom_word_t w;
        h = 16'(addr * 40503 + 12345);
        h = h ^ 16'(addr >> 5);
        w = '0;
        for (int i = 0; i < 4; i++) begin
            n = h[i*4 +: 4];
            // high values turn transparent, gives holes in every object
            if (n >= 4'd12) begin
                n = 4'd0;
            end
            w[i*4 +: 4] = n;
        end
        return w;
    endfunction

    // first enabled slot with an opaque pixel at (x, y), lowest slot first
    function automatic obj_pkg::pix_t expected_pixel(input int x, input int y);
        int                 row;
        int                 dx;
        int                 addr;
        obj_pkg::rom_word_t w;
        obj_pkg::pix_t      p;
        for (int s = 0; s < obj_pkg::OBJ_SLOTS; s++) begin
            row = (y - int'(attr_tab[s].y)) & 63;
            dx  = x - int'(attr_tab[s].x);
            if (attr_tab[s].enable && row < obj_pkg::OBJ_SIZE && dx >= 0
                    && dx < obj_pkg::OBJ_SIZE) begin
                addr = int'(attr_tab[s].code) * 64 + row * 4 + dx / 4;
                w    = rom_word_at(addr);
                p    = obj_pkg::pix_t'(w >> (4 * (dx % 4)));
                if (p != '0) begin
                    return p;
                end
            end
        end
        return '0;
    endfunction

    task automatic compare_color(input string name, input obj_pkg::pix_t exp,
                                 input obj_pkg::pix_t act, input int x, input int y);
        if (act !== exp) begin
            fail_with($sformatf("ERROR %s: pixel (%0d,%0d) expected %h actual %h",
                                name, x, y, exp, act));
        end
    endtask

    // position only, colour has its own compare
    task automatic compare_place(input string name, input obj_pkg::pix_out_t exp,
                                 input obj_pkg::pix_out_t act);
        if (act.x !== exp.x || act.y !== exp.y) begin
            fail_with($sformatf("ERROR %s: position expected (%0d,%0d) actual (%0d,%0d)",
                                name, exp.x, exp.y, act.x, act.y));
        end
    endtask

    task automatic compare_attr(input string name, input obj_pkg::obj_attr_t exp,
                                input obj_pkg::obj_attr_t act, input int slot);
        if (act !== exp) begin
            fail_with($sformatf("ERROR %s: slot %0d expected %h actual %h",
                                name, slot, exp, act));
        end
    endtask

    // rom model, one ok pulse after 0 to 3 extra cycles
    always @(posedge clk) begin
        if (rst) begin
            rom_ok   <= 1'b0;
            rom_busy <= 1'b0;
        end else if (rom_ok) begin
            rom_ok   <= 1'b0;
            rom_busy <= 1'b0;
        end else if (rom_req.req && !rom_busy) begin
            rom_busy <= 1'b1;
            rom_wait <= $random(seed) & ROM_MAX_WAIT;
        end else if (rom_busy) begin
            if (rom_wait == 0) begin
                rom_ok   <= 1'b1;
                rom_data <= rom_word_at(int'(rom_req.addr));
            end else begin
                rom_wait <= rom_wait - 1;
            end
        end
    end

    // every shown pixel against the reference, in raster order
    always @(posedge clk) begin
        if (check_en && pix_out.valid) begin
            exp_place.valid = 1'b1;
            exp_place.x     = 7'(pix_seen % video_pkg::H_ACTIVE);
            exp_place.y     = 5'(pix_seen / video_pkg::H_ACTIVE);
            exp_place.color = '0;
            compare_place(test_name, exp_place, pix_out);
            compare_color(test_name, expected_pixel(int'(exp_place.x), int'(exp_place.y)),
                          pix_out.color, int'(exp_place.x), int'(exp_place.y));
            if (pix_out.color != '0) begin
                opaque_seen++;
            end
            pix_seen++;
        end
    end

    task automatic wait_reset_release();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > 10) begin
                fail_with("reset never released");
            end
        end while (rst);
    endtask

    // one classic cycle, master holds the request until ack
    task automatic wb_cycle(input logic we, input obj_pkg::obj_idx_t adr,
                            input logic [31:0] dat, output logic [31:0] rdat);
        int n;
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > WB_TIMEOUT) begin
                fail_with("no wishbone ack within the timeout");
            end
        end while (!wb_rsp.ack);
        rdat = wb_rsp.dat;
        wb_req <= '0;
        @(posedge clk);
        if (wb_rsp.ack) begin
            fail_with("wishbone ack stayed high for more than one cycle");
        end
    endtask

    task automatic write_attr(input int slot, input obj_pkg::obj_attr_t a);
        logic [31:0] unused;
        attr_tab[slot] = a;
        wb_cycle(1'b1, obj_pkg::obj_idx_t'(slot), 32'(a), unused);
    endtask

    task automatic clear_table();
        for (int s = 0; s < obj_pkg::OBJ_SLOTS; s++) begin
            write_attr(s, '0);
        end
    endtask

    function automatic obj_pkg::obj_attr_t make_attr(input int x, input int y,
                                                     input int code);
        obj_pkg::obj_attr_t a;
        a        = '0;
        a.x      = 8'(x);
        a.y      = 6'(y);
        a.enable = 1'b1;
        a.code   = 8'(code);
        return a;
    endfunction

    // whole frame after the table has settled
    task automatic check_frame(input string name, input bit need_opaque);
        int n;
        test_name = name;
        // end of a visible frame, next frame is scanned from the new table
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > 2 * FRAME_CYCLES) begin
                fail_with("timeout waiting for the end of a frame");
            end
        end while (!(pix_out.valid && pix_out.x == 7'd127 && pix_out.y == 5'd31));
        pix_seen    = 0;
        opaque_seen = 0;
        check_en <= 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > FRAME_CYCLES + video_pkg::H_TOTAL) begin
                fail_with($sformatf("frame in %s ended with only %0d pixels", name, pix_seen));
            end
        end while (pix_seen < FRAME_PIXELS);
        check_en <= 1'b0;
        if (need_opaque && opaque_seen == 0) begin
            fail_with($sformatf("no object pixel was shown in %s", name));
        end
    endtask

    initial begin
        logic [31:0]        rd;
        obj_pkg::obj_attr_t a;
        int                 n_en;
        obj_pkg::obj_attr_t rb_tab [obj_pkg::OBJ_SLOTS];
        obj_pkg::obj_attr_t rnd_tab [2][obj_pkg::OBJ_SLOTS];

        // all random tables drawn before the first clock edge
        for (int s = 0; s < obj_pkg::OBJ_SLOTS; s++) begin
            rb_tab[s] = obj_pkg::obj_attr_t'($random(seed));
        end
        for (int r = 0; r < 2; r++) begin
            for (int s = 0; s < obj_pkg::OBJ_SLOTS; s++) begin
                rnd_tab[r][s] = obj_pkg::obj_attr_t'($random(seed));
            end
        end
        wait_reset_release();

        // write then read back all slots
        test_name = "wb_readback";
        for (int s = 0; s < obj_pkg::OBJ_SLOTS; s++) begin
            write_attr(s, rb_tab[s]);
        end
        for (int s = 0; s < obj_pkg::OBJ_SLOTS; s++) begin
            wb_cycle(1'b0, obj_pkg::obj_idx_t'(s), '0, rd);
            compare_attr(test_name, attr_tab[s], obj_pkg::obj_attr_t'(rd), s);
        end

        clear_table();
        check_frame("all_disabled", 1'b0);

        // lone object, then one hanging off the right edge
        write_attr(5, make_attr(40, 10, 8'h21));
        check_frame("single_object", 1'b1);
        write_attr(5, make_attr(120, 20, 8'h5a));
        check_frame("single_clipped", 1'b1);

        // three overlapping objects
        clear_table();
        write_attr(2, make_attr(50, 12, 8'h10));
        write_attr(7, make_attr(56, 16, 8'h33));
        write_attr(11, make_attr(44, 8, 8'h44));
        check_frame("overlap", 1'b1);

        // random tables, enabled count capped
        for (int r = 0; r < 2; r++) begin
            n_en = 0;
            for (int s = 0; s < obj_pkg::OBJ_SLOTS; s++) begin
                a = rnd_tab[r][s];
                if (a.enable) begin
                    if (n_en >= MAX_RANDOM_OBJS) begin
                        a.enable = 1'b0;
                    end else begin
                        n_en++;
                    end
                end
                write_attr(s, a);
            end
            check_frame($sformatf("random_%0d", r), 1'b0);
        end

        // bottom line object and one wrapping onto lines 0..11
        clear_table();
        write_attr(0, make_attr(10, 31, 8'h77));
        write_attr(1, make_attr(60, 60, 8'h0c));
        check_frame("y_wrap", 1'b1);

        if (error_count == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("Testbench failed");
            $fatal(1, "checks reported errors");
        end
    end

endmodule

/* sim/obj_engine_checker.sv */
`timescale 1ns/10ps

// handshake and output checks on the engine top level
module obj_engine_checker (
    input logic                 clk,
    input logic                 rst,
    input obj_pkg::wb_req_t     wb_req,
    input obj_pkg::wb_rsp_t     wb_rsp,
    input obj_pkg::rom_req_t    rom_req,
    input logic                 rom_ok,
    input obj_pkg::pix_out_t    pix_out,
    input video_pkg::beam_pos_t beam
);

    // ack answers a cyc and stb seen the cycle before
    ack_after_req: assert property (@(posedge clk) disable iff (rst)
        wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
        else $error("wishbone ack without a preceding cyc and stb");

    // request and address held until the rom answers
    rom_addr_hold: assert property (@(posedge clk) disable iff (rst)
        (rom_req.req && !rom_ok) |=> (rom_req.req && $stable(rom_req.addr)))
        else $error("rom request or address changed before rom_ok");

    // output is registered one cycle behind the beam
    pix_in_active: assert property (@(posedge clk) disable iff (rst)
        pix_out.valid |-> $past(!beam.hblank && !beam.vblank))
        else $error("pixel marked valid during blanking");

endmodule

bind obj_engine_top obj_engine_checker u_checker (
    .clk     (clk),
    .rst     (rst),
    .wb_req  (wb_req),
    .wb_rsp  (wb_rsp),
    .rom_req (rom_req),
    .rom_ok  (rom_ok),
    .pix_out (pix_out),
    .beam    (beam)
);

/* sim/tb_clock_gen.sv */
`timescale 1ns/10ps

// testbench clock and reset source
module tb_clock_gen (
    output logic clk,
    output logic rst
);

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // reset held for two rising edges
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* rtl/obj_engine_top.sv */
`timescale 1ns/10ps

// scanline object engine
module obj_engine_top (
    input  logic                clk,
    input  logic                rst,
    input  obj_pkg::wb_req_t    wb_req,
    output obj_pkg::wb_rsp_t    wb_rsp,
    output obj_pkg::rom_req_t   rom_req,
    input  logic                rom_ok,
    input  obj_pkg::rom_word_t  rom_data,
    output obj_pkg::pix_out_t   pix_out
);

    video_pkg::beam_pos_t beam;
    obj_pkg::obj_idx_t    slot;
    obj_pkg::obj_attr_t   attr;
    logic                 attr_load;
    logic                 fetch_go;
    logic [1:0]           word_step;
    logic                 bank;
    logic                 obj_hit;
    logic                 fetch_done;
    logic                 wr_en;
    logic [7:0]           wr_x;
    obj_pkg::pix_t        wr_color;

    video_timing u_timing (
        .clk  (clk),
        .rst  (rst),
        .beam (beam)
    );

    obj_scan_ctrl u_scan (
        .clk        (clk),
        .rst        (rst),
        .beam       (beam),
        .obj_hit    (obj_hit),
        .fetch_done (fetch_done),
        .slot       (slot),
        .attr_load  (attr_load),
        .fetch_go   (fetch_go),
        .word_step  (word_step),
        .over       (),
        .bank       (bank)
    );

    obj_attr_ram u_attr (
        .clk    (clk),
        .rst    (rst),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .slot   (slot),
        .attr   (attr)
    );

    obj_draw u_draw (
        .clk        (clk),
        .rst        (rst),
        .beam       (beam),
        .attr       (attr),
        .attr_load  (attr_load),
        .fetch_go   (fetch_go),
        .word_step  (word_step),
        .obj_hit    (obj_hit),
        .rom_req    (rom_req),
        .rom_ok     (rom_ok),
        .rom_data   (rom_data),
        .fetch_done (fetch_done),
        .wr_en      (wr_en),
        .wr_x       (wr_x),
        .wr_color   (wr_color)
    );

    obj_linebuf u_linebuf (
        .clk      (clk),
        .rst      (rst),
        .bank     (bank),
        .wr_en    (wr_en),
        .wr_x     (wr_x),
        .wr_color (wr_color),
        .beam     (beam),
        .pix_out  (pix_out)
    );

endmodule

/* rtl/obj_linebuf.sv */
`timescale 1ns/10ps

// double line buffer
// bank "bank" takes draw writes, the other one is shown and cleared
module obj_linebuf (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  bank,
    input  logic                  wr_en,
    input  logic [7:0]            wr_x,
    input  obj_pkg::pix_t         wr_color,
    input  video_pkg::beam_pos_t  beam,
    output obj_pkg::pix_out_t     pix_out
);

    obj_pkg::pix_t buf_mem [2][video_pkg::H_ACTIVE];

    logic          rd_bank;
    logic          rd_en;
    logic [6:0]    rd_x;
    logic          wr_ok;
    logic          valid_q;
    logic [6:0]    x_q;
    logic [4:0]    y_q;
    obj_pkg::pix_t color_q;

    // bank flips at the end of the line_start cycle, column 0 still sees the old value
    assign rd_bank = beam.line_start ? bank : ~bank;
    // clear runs on every line so vblank leftovers never reach line 0
    assign rd_en   = !beam.hblank;
    assign rd_x    = beam.hcount[6:0];

    // first writer keeps the pixel, so the lower slot wins
    assign wr_ok = wr_en && !wr_x[7] && (buf_mem[bank][wr_x[6:0]] == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int b = 0; b < 2; b++) begin
                for (int i = 0; i < video_pkg::H_ACTIVE; i++) begin
                    buf_mem[b][i] <= '0;
                end
            end
        end else begin
            if (wr_ok) begin
                buf_mem[bank][wr_x[6:0]] <= wr_color;
            end
            // read then clear in one go
            if (rd_en) begin
                buf_mem[rd_bank][rd_x] <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= rd_en && !beam.vblank;
        end
    end

    always_ff @(posedge clk) begin
        x_q     <= rd_x;
        y_q     <= beam.vcount[4:0];
        color_q <= buf_mem[rd_bank][rd_x];
    end

    assign pix_out = '{valid: valid_q, x: x_q, y: y_q, color: color_q};

endmodule

/* rtl/obj_draw.sv */
`timescale 1ns/10ps

// object draw unit
// hit test for the next line, rom fetch, pixel writes into the line buffer
module obj_draw (
    input  logic                  clk,
    input  logic                  rst,
    input  video_pkg::beam_pos_t  beam,
    input  obj_pkg::obj_attr_t    attr,
    input  logic                  attr_load,
    input  logic                  fetch_go,
    input  logic [1:0]            word_step,
    output logic                  obj_hit,
    output obj_pkg::rom_req_t     rom_req,
    input  logic                  rom_ok,
    input  obj_pkg::rom_word_t    rom_data,
    output logic                  fetch_done,
    output logic                  wr_en,
    output logic [7:0]            wr_x,
    output obj_pkg::pix_t         wr_color
);

    obj_pkg::obj_attr_t attr_q;
    obj_pkg::rom_word_t shift_q;
    logic [5:0]                target_line;
    logic [5:0]                row_full;
    logic [3:0]                row_q;
    logic                      hit_q;
    logic                      pend;
    logic                      launch;
    logic                      req_q;
    logic [obj_pkg::ROM_AW-1:0] addr_q;
    logic                      done_q;
    logic [2:0]                shift_cnt;
    logic [8:0]                col_q;

    // scan during line v draws line v+1
    assign target_line = (beam.vcount == 6'(video_pkg::V_TOTAL - 1)) ? 6'd0
                                                                     : beam.vcount + 6'd1;
    // modulo 64 distance from the object top
    assign row_full = target_line - attr.y;

    always_ff @(posedge clk) begin
        if (rst) begin
            hit_q <= 1'b0;
        end else if (attr_load) begin
            hit_q <= attr.enable && (row_full < 6'(obj_pkg::OBJ_SIZE));
        end
    end

    always_ff @(posedge clk) begin
        if (attr_load) begin
            attr_q <= attr;
            row_q  <= row_full[3:0];
        end
    end

    // hold the request back until the shifter can take new data next cycle
    assign launch = !req_q && (pend || fetch_go) && (shift_cnt <= 3'd2);

    always_ff @(posedge clk) begin
        if (rst) begin
            req_q  <= 1'b0;
            pend   <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (fetch_go) begin
                pend <= 1'b1;
            end
            if (req_q) begin
                // data taken now, req drops next cycle
                if (rom_ok) begin
                    req_q  <= 1'b0;
                    done_q <= 1'b1;
                end
            end else if (launch) begin
                req_q <= 1'b1;
                pend  <= 1'b0;
            end
        end
    end

    // address stays put while req is up
    always_ff @(posedge clk) begin
        if (launch) begin
            addr_q <= {attr_q.code, row_q, word_step};
        end
    end

    // pixel shifter, one pixel per cycle after rom_ok
    always_ff @(posedge clk) begin
        if (rst) begin
            shift_cnt <= '0;
        end else if (req_q && rom_ok) begin
            shift_cnt <= 3'd4;
        end else if (shift_cnt != '0) begin
            shift_cnt <= shift_cnt - 3'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (req_q && rom_ok) begin
            shift_q <= rom_data;
            // 9 bits so x near 255 does not wrap onto the left edge
            col_q   <= {1'b0, attr_q.x} + {5'd0, word_step, 2'b00};
        end else if (shift_cnt != '0) begin
            shift_q <= shift_q >> obj_pkg::PIX_W;
            col_q   <= col_q + 9'd1;
        end
    end

    // transparent and off-screen pixels are skipped
    assign wr_en = (shift_cnt != '0) && (shift_q[3:0] != '0)
                   && (col_q < 9'(video_pkg::H_ACTIVE));
    assign wr_x     = col_q[7:0];
    assign wr_color = shift_q[3:0];

    assign obj_hit    = hit_q;
    assign fetch_done = done_q;
    assign rom_req    = '{addr: addr_q, req: req_q};

endmodule

/* rtl/obj_attr_ram.sv */
`timescale 1ns/10ps

// object attribute table
// wishbone classic on the cpu side, registered read port for the scanner
module obj_attr_ram (
    input  logic                clk,
    input  logic                rst,
    input  obj_pkg::wb_req_t    wb_req,
    output obj_pkg::wb_rsp_t    wb_rsp,
    input  obj_pkg::obj_idx_t   slot,
    output obj_pkg::obj_attr_t  attr
);

    obj_pkg::obj_attr_t attr_mem [obj_pkg::OBJ_SLOTS];

    logic        ack_q;
    logic [31:0] rd_dat_q;
    logic        access;

    // new access only while ack is low, so each ack is one cycle
    assign access = wb_req.cyc && wb_req.stb && !ack_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q <= 1'b0;
            // only the enables, the rest is don't care when disabled
            for (int i = 0; i < obj_pkg::OBJ_SLOTS; i++) begin
                attr_mem[i].enable <= 1'b0;
            end
        end else begin
            ack_q <= access;
            // write lands together with ack
            if (access && wb_req.we) begin
                attr_mem[wb_req.adr] <= obj_pkg::obj_attr_t'(wb_req.dat);
            end
        end
    end

    // read data lines up with ack
    always_ff @(posedge clk) begin
        if (access) begin
            rd_dat_q <= attr_mem[wb_req.adr];
        end
    end

    // scanner port, one cycle behind slot
    always_ff @(posedge clk) begin
        attr <= attr_mem[slot];
    end

    assign wb_rsp = '{ack: ack_q, dat: rd_dat_q};

endmodule

/* rtl/obj_scan_ctrl.sv */
`timescale 1ns/10ps

// per line object scan sequencer
// walks all slots, fetches four rom words for every hit
module obj_scan_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  video_pkg::beam_pos_t  beam,
    input  logic                  obj_hit,
    input  logic                  fetch_done,
    output obj_pkg::obj_idx_t     slot,
    output logic                  attr_load,
    output logic                  fetch_go,
    output logic [1:0]            word_step,
    output logic                  over,
    output logic                  bank
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_WAIT,
        S_LOAD,
        S_HIT,
        S_GO,
        S_DONE,
        S_NEXT
    } state_t;

    state_t     state;
    logic       wait_cnt;
    logic [1:0] word;
    logic       last_slot;
    logic       last_word;

    assign last_slot = (slot == obj_pkg::obj_idx_t'(obj_pkg::OBJ_SLOTS - 1));
    assign last_word = (word == 2'(obj_pkg::WORDS_PER_ROW - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= S_IDLE;
            slot     <= '0;
            wait_cnt <= 1'b0;
            word     <= '0;
            over     <= 1'b0;
            bank     <= 1'b0;
        end else if (beam.line_start) begin
            // restart, even if the last scan ran long
            state    <= S_WAIT;
            slot     <= '0;
            wait_cnt <= 1'b0;
            word     <= '0;
            over     <= 1'b0;
            bank     <= ~bank;
        end else begin
            case (state)
                S_WAIT: begin
                    // two cycles for the registered attribute read
                    wait_cnt <= ~wait_cnt;
                    if (wait_cnt) begin
                        state <= S_LOAD;
                    end
                end
                S_LOAD: begin
                    state <= S_HIT;
                end
                S_HIT: begin
                    // obj_hit settles the cycle after attr_load
                    word <= '0;
                    if (obj_hit) begin
                        state <= S_GO;
                    end else begin
                        state <= S_NEXT;
                    end
                end
                S_GO: begin
                    state <= S_DONE;
                end
                S_DONE: begin
                    // stalls here while the rom holds off
                    if (fetch_done) begin
                        if (last_word) begin
                            state <= S_NEXT;
                        end else begin
                            word  <= word + 2'd1;
                            state <= S_GO;
                        end
                    end
                end
                S_NEXT: begin
                    if (last_slot) begin
                        over  <= 1'b1;
                        state <= S_IDLE;
                    end else begin
                        slot     <= slot + 1'b1;
                        wait_cnt <= 1'b0;
                        state    <= S_WAIT;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // single cycle strobes from the state
    assign attr_load = (state == S_LOAD);
    assign fetch_go  = (state == S_GO);
    assign word_step = word;

endmodule

/* rtl/video_timing.sv */
`timescale 1ns/10ps

// free running beam counters
module video_timing (
    input  logic                  clk,
    input  logic                  rst,
    output video_pkg::beam_pos_t  beam
);

    logic [video_pkg::HCNT_W-1:0] hcount;
    logic [video_pkg::VCNT_W-1:0] vcount;
    logic                         h_last;
    logic                         v_last;
    logic                         hblank;
    logic                         vblank;

    // last column and last line of the frame
    assign h_last = (hcount == video_pkg::HCNT_W'(video_pkg::H_TOTAL - 1));
    assign v_last = (vcount == video_pkg::VCNT_W'(video_pkg::V_TOTAL - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
        end else begin
            if (h_last) begin
                hcount <= '0;
                // vertical step once per line
                if (v_last) begin
                    vcount <= '0;
                end else begin
                    vcount <= vcount + 1'b1;
                end
            end else begin
                hcount <= hcount + 1'b1;
            end
        end
    end

    // blanking straight from the counters
    assign hblank = (hcount >= video_pkg::HCNT_W'(video_pkg::H_ACTIVE));
    assign vblank = (vcount >= video_pkg::VCNT_W'(video_pkg::V_ACTIVE));

    // line_start marks column 0, vcount already holds the new line there
    assign beam = '{
        hcount:     hcount,
        vcount:     vcount,
        hblank:     hblank,
        vblank:     vblank,
        line_start: (hcount == '0)
    };

endmodule

/* rtl/obj_pkg.sv */
// object engine types
// slot table, attribute layout, graphics ROM and pixel output
package obj_pkg;

    localparam int OBJ_SLOTS     = 16;
    localparam int OBJ_SIZE      = 16;
    localparam int WORDS_PER_ROW = 4;

    // rom address is {code, row, word}
    localparam int ROM_AW = 14;
    localparam int PIX_W  = 4;

    typedef logic [$clog2(OBJ_SLOTS)-1:0] obj_idx_t;

    // attribute word, msb first
    typedef struct packed {
        logic [7:0] x;
        logic [5:0] y;
        logic       enable;
        logic       reserved;
        // graphics number
        logic [7:0] code;
        logic [7:0] spare;
    } obj_attr_t;

    typedef struct packed {
        logic [ROM_AW-1:0] addr;
        logic              req;
    } rom_req_t;

    // four pixels, pixel 0 in bits 3:0
    typedef logic [15:0] rom_word_t;

    // colour 0 means transparent
    typedef logic [PIX_W-1:0] pix_t;

    typedef struct packed {
        logic       valid;
        logic [6:0] x;
        logic [4:0] y;
        pix_t       color;
    } pix_out_t;

    // wishbone classic, cpu side
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        obj_idx_t    adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

endpackage

/* rtl/video_pkg.sv */
// screen geometry for the object engine
// one clock per horizontal step, no clock enables
package video_pkg;

    // horizontal: cycles per line and visible columns
    localparam int H_TOTAL  = 320;
    localparam int H_ACTIVE = 128;

    // vertical: lines per frame and visible lines
    localparam int V_TOTAL  = 36;
    localparam int V_ACTIVE = 32;

    // widths of the beam counters
    localparam int HCNT_W = 9;
    localparam int VCNT_W = 6;

    // beam position shared by every block
    typedef struct packed {
        logic [HCNT_W-1:0] hcount;
        logic [VCNT_W-1:0] vcount;
        logic              hblank;
        logic              vblank;
        // high for the single cycle where hcount is back at 0
        logic              line_start;
    } beam_pos_t;

endpackage
